// File: rv_isa_pkg.sv
// RV32I base subset only: no FENCE, SYSTEM or compressed encodings are defined here
package rv_isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_t;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_MEM_B  = 3'b000;
    localparam logic [2:0] F3_MEM_H  = 3'b001;
    localparam logic [2:0] F3_MEM_W  = 3'b010;
    localparam logic [2:0] F3_MEM_BU = 3'b100;
    localparam logic [2:0] F3_MEM_HU = 3'b101;

    // Integer operations, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One instruction word, seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

// File: rv_ctrl_pkg.sv
// Internal select encodings of the core; the values carry no meaning outside it
package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_control_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_source_t;

    typedef enum logic {
        ALU_SRC_REG,
        ALU_SRC_IMM
    } alu_source_t;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS_FOUR,
        WB_TARGET
    } wb_source_t;

    // Second adder operands: AUIPC and branches, LUI, JALR
    typedef enum logic [1:0] {
        TGT_PC_IMM,
        TGT_IMM,
        TGT_RS1_IMM
    } target_source_t;

endpackage

// File: fetch_unit.sv
// Program counter with no stall input; RESET_ADDR must be word aligned
module fetch_unit #(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_pc_source,
    input  rv_ctrl_pkg::target_source_t i_target_source,
    input  logic [31:0]                 i_imm,
    input  logic [31:0]                 i_rs1_data,
    output logic [31:0]                 o_pc,
    output logic [31:0]                 o_pc_plus_four,
    output logic [31:0]                 o_target
);

    import rv_ctrl_pkg::*;

    logic [31:0] rs1_sum;

    assign o_pc_plus_four = o_pc + 32'd4;
    assign rs1_sum        = i_rs1_data + i_imm;

    // Second adder, also feeds LUI and AUIPC write-back
    always_comb begin
        case (i_target_source)
            TGT_IMM:     o_target = i_imm;
            TGT_RS1_IMM: o_target = {rs1_sum[31:1], 1'b0};
            default:     o_target = o_pc + i_imm;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= RESET_ADDR;
        end else begin
            o_pc <= i_pc_source ? o_target : o_pc_plus_four;
        end
    end

endmodule

// File: decode_control.sv
// Unsupported opcodes decode as no-ops: no register write, no store, sequential pc
module decode_control (
    input  rv_isa_pkg::instr_t          i_instr,
    input  logic                        i_alu_zero,
    input  logic                        i_alu_last_bit,
    output rv_ctrl_pkg::alu_control_t   o_alu_control,
    output rv_ctrl_pkg::imm_source_t    o_imm_source,
    output rv_ctrl_pkg::alu_source_t    o_alu_source,
    output rv_ctrl_pkg::wb_source_t     o_wb_source,
    output rv_ctrl_pkg::target_source_t o_target_source,
    output logic                        o_reg_write,
    output logic                        o_mem_write,
    output logic                        o_pc_source
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_t      opcode;
    logic [2:0]   funct3;
    logic         funct7_b5;
    alu_control_t arith_op;
    alu_control_t branch_op;
    logic         branch_taken;

    assign opcode    = i_instr.r_fmt.opcode;
    assign funct3    = i_instr.r_fmt.funct3;
    assign funct7_b5 = i_instr.r_fmt.funct7[5];

    // Bit 30 selects SUB only for OP, since in OP-IMM it belongs to the immediate
    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = (opcode == OP_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    // Equality through the zero flag, ordering through the SLT result bit
    always_comb begin
        case (funct3)
            F3_BLT, F3_BGE:   branch_op = ALU_SLT;
            F3_BLTU, F3_BGEU: branch_op = ALU_SLTU;
            default:          branch_op = ALU_SUB;
        endcase
        case (funct3)
            F3_BEQ:           branch_taken = i_alu_zero;
            F3_BNE:           branch_taken = !i_alu_zero;
            F3_BLT, F3_BLTU:  branch_taken = i_alu_last_bit;
            F3_BGE, F3_BGEU:  branch_taken = !i_alu_last_bit;
            default:          branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        o_alu_control   = ALU_ADD;
        o_imm_source    = IMM_I;
        o_alu_source    = ALU_SRC_REG;
        o_wb_source     = WB_ALU;
        o_target_source = TGT_PC_IMM;
        o_reg_write     = 1'b0;
        o_mem_write     = 1'b0;
        o_pc_source     = 1'b0;
        case (opcode)
            OP_LUI: begin
                o_imm_source    = IMM_U;
                o_target_source = TGT_IMM;
                o_wb_source     = WB_TARGET;
                o_reg_write     = 1'b1;
            end
            OP_AUIPC: begin
                o_imm_source = IMM_U;
                o_wb_source  = WB_TARGET;
                o_reg_write  = 1'b1;
            end
            OP_JAL: begin
                o_imm_source = IMM_J;
                o_wb_source  = WB_PC_PLUS_FOUR;
                o_reg_write  = 1'b1;
                o_pc_source  = 1'b1;
            end
            OP_JALR: begin
                o_target_source = TGT_RS1_IMM;
                o_wb_source     = WB_PC_PLUS_FOUR;
                o_reg_write     = 1'b1;
                o_pc_source     = 1'b1;
            end
            OP_BRANCH: begin
                o_imm_source  = IMM_B;
                o_alu_control = branch_op;
                o_pc_source   = branch_taken;
            end
            OP_LOAD: begin
                o_alu_source = ALU_SRC_IMM;
                o_wb_source  = WB_MEM;
                o_reg_write  = 1'b1;
            end
            OP_STORE: begin
                o_imm_source = IMM_S;
                o_alu_source = ALU_SRC_IMM;
                o_mem_write  = 1'b1;
            end
            OP_IMM: begin
                o_alu_control = arith_op;
                o_alu_source  = ALU_SRC_IMM;
                o_reg_write   = 1'b1;
            end
            OP_OP: begin
                o_alu_control = arith_op;
                o_reg_write   = 1'b1;
            end
            default: begin
                o_reg_write = 1'b0;
            end
        endcase
    end

endmodule

// File: imm_gen.sv
// Immediates for the five RV32I formats; an unknown select yields zero
module imm_gen (
    input  rv_isa_pkg::instr_t       i_instr,
    input  rv_ctrl_pkg::imm_source_t i_imm_source,
    output logic [31:0]              o_imm
);

    import rv_ctrl_pkg::*;

    always_comb begin
        case (i_imm_source)
            IMM_I: o_imm = {{20{i_instr.i_fmt.imm_11_0[11]}}, i_instr.i_fmt.imm_11_0};
            IMM_S: o_imm = {{20{i_instr.s_fmt.imm_11_5[6]}}, i_instr.s_fmt.imm_11_5,
                            i_instr.s_fmt.imm_4_0};
            IMM_B: o_imm = {{19{i_instr.b_fmt.imm_12}}, i_instr.b_fmt.imm_12,
                            i_instr.b_fmt.imm_11, i_instr.b_fmt.imm_10_5,
                            i_instr.b_fmt.imm_4_1, 1'b0};
            // Upper immediate already sits in bits 31:12
            IMM_U: o_imm = {i_instr.u_fmt.imm_31_12, 12'h000};
            IMM_J: o_imm = {{11{i_instr.j_fmt.imm_20}}, i_instr.j_fmt.imm_20,
                            i_instr.j_fmt.imm_19_12, i_instr.j_fmt.imm_11,
                            i_instr.j_fmt.imm_10_1, 1'b0};
            default: o_imm = 32'h0000_0000;
        endcase
    end

endmodule

// File: regfile.sv
// 32 x 32 registers with asynchronous reads; a read of a register written this cycle sees the old value
module regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  i_rs1_addr,
    input  logic [4:0]  i_rs2_addr,
    input  logic [4:0]  i_rd_addr,
    input  logic        i_write_enable,
    input  logic [31:0] i_write_data,
    output logic [31:0] o_rs1_data,
    output logic [31:0] o_rs2_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (i_write_enable && i_rd_addr != 5'd0) begin
            regs[i_rd_addr] <= i_write_data;
        end
    end

    // x0 always reads zero
    assign o_rs1_data = (i_rs1_addr == 5'd0) ? 32'h0000_0000 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == 5'd0) ? 32'h0000_0000 : regs[i_rs2_addr];

endmodule

// File: alu.sv
// Shift amounts use only the low five bits of the second operand
module alu (
    input  rv_ctrl_pkg::alu_control_t i_alu_control,
    input  logic [31:0]               i_src1,
    input  logic [31:0]               i_src2,
    output logic [31:0]               o_result,
    output logic                      o_zero,
    output logic                      o_last_bit
);

    import rv_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_src2[4:0];

    always_comb begin
        case (i_alu_control)
            ALU_ADD:  o_result = i_src1 + i_src2;
            ALU_SUB:  o_result = i_src1 - i_src2;
            ALU_SLL:  o_result = i_src1 << shamt;
            ALU_SLT:  o_result = {31'd0, $signed(i_src1) < $signed(i_src2)};
            ALU_SLTU: o_result = {31'd0, i_src1 < i_src2};
            ALU_XOR:  o_result = i_src1 ^ i_src2;
            ALU_SRL:  o_result = i_src1 >> shamt;
            ALU_SRA:  o_result = $unsigned($signed(i_src1) >>> shamt);
            ALU_OR:   o_result = i_src1 | i_src2;
            ALU_AND:  o_result = i_src1 & i_src2;
            default:  o_result = 32'h0000_0000;
        endcase
    end

    // Flags for branch resolution in the decoder
    assign o_zero     = (o_result == 32'h0000_0000);
    assign o_last_bit = o_result[0];

endmodule

// File: mem_access.sv
// Assumes naturally aligned accesses; misaligned half and word addresses are not detected
module mem_access (
    input  logic [31:0] i_addr,
    input  logic [31:0] i_store_data,
    input  logic [2:0]  i_funct3,
    input  logic        i_mem_write,
    input  logic [31:0] i_rdata,
    output logic [31:0] o_dmem_addr,
    output logic [31:0] o_dmem_wdata,
    output logic [3:0]  o_dmem_be,
    output logic        o_dmem_we,
    output logic [31:0] o_load_data
);

    import rv_isa_pkg::*;

    logic [1:0]  offset;
    logic [3:0]  lane_mask;
    logic [31:0] lane_data;

    assign offset      = i_addr[1:0];
    assign o_dmem_addr = {i_addr[31:2], 2'b00};
    assign o_dmem_we   = i_mem_write;

    // Replicated store data lands on every lane; the enables pick the right one
    always_comb begin
        case (i_funct3)
            F3_MEM_B: begin
                o_dmem_wdata = {4{i_store_data[7:0]}};
                lane_mask    = 4'b0001 << offset;
            end
            F3_MEM_H: begin
                o_dmem_wdata = {2{i_store_data[15:0]}};
                lane_mask    = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_dmem_wdata = i_store_data;
                lane_mask    = 4'b1111;
            end
        endcase
    end

    assign o_dmem_be = i_mem_write ? lane_mask : 4'b0000;

    // Move the addressed lane down to bit 0
    assign lane_data = i_rdata >> {offset, 3'b000};

    always_comb begin
        case (i_funct3)
            F3_MEM_B:  o_load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            F3_MEM_H:  o_load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            F3_MEM_BU: o_load_data = {24'd0, lane_data[7:0]};
            F3_MEM_HU: o_load_data = {16'd0, lane_data[15:0]};
            F3_MEM_W:  o_load_data = i_rdata;
            default:   o_load_data = i_rdata;
        endcase
    end

endmodule

// File: rv_core.sv
// Single-cycle RV32I core; both memories must answer combinationally within the cycle
module rv_core #(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic [31:0]        o_imem_addr,
    input  rv_isa_pkg::instr_t i_imem_data,
    output logic [31:0]        o_dmem_addr,
    output logic [31:0]        o_dmem_wdata,
    output logic [3:0]         o_dmem_be,
    output logic               o_dmem_we,
    input  logic [31:0]        i_dmem_rdata
);

    import rv_ctrl_pkg::*;

    logic [31:0]    pc;
    logic [31:0]    pc_plus_four;
    logic [31:0]    target;
    logic [31:0]    imm;
    logic [31:0]    rs1_data;
    logic [31:0]    rs2_data;
    logic [31:0]    alu_src2;
    logic [31:0]    alu_result;
    logic           alu_zero;
    logic           alu_last_bit;
    logic [31:0]    load_data;
    logic [31:0]    wb_data;
    alu_control_t   alu_control;
    imm_source_t    imm_source;
    alu_source_t    alu_source;
    wb_source_t     wb_source;
    target_source_t target_source;
    logic           reg_write;
    logic           mem_write;
    logic           pc_source;

    assign o_imem_addr = pc;

    fetch_unit #(
        .RESET_ADDR(RESET_ADDR)
    ) u_fetch_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_pc_source     (pc_source),
        .i_target_source (target_source),
        .i_imm           (imm),
        .i_rs1_data      (rs1_data),
        .o_pc            (pc),
        .o_pc_plus_four  (pc_plus_four),
        .o_target        (target)
    );

    decode_control u_decode_control (
        .i_instr         (i_imem_data),
        .i_alu_zero      (alu_zero),
        .i_alu_last_bit  (alu_last_bit),
        .o_alu_control   (alu_control),
        .o_imm_source    (imm_source),
        .o_alu_source    (alu_source),
        .o_wb_source     (wb_source),
        .o_target_source (target_source),
        .o_reg_write     (reg_write),
        .o_mem_write     (mem_write),
        .o_pc_source     (pc_source)
    );

    imm_gen u_imm_gen (
        .i_instr      (i_imem_data),
        .i_imm_source (imm_source),
        .o_imm        (imm)
    );

    // Write-back select
    always_comb begin
        case (wb_source)
            WB_MEM:          wb_data = load_data;
            WB_PC_PLUS_FOUR: wb_data = pc_plus_four;
            WB_TARGET:       wb_data = target;
            default:         wb_data = alu_result;
        endcase
    end

    // No architectural writes while reset is held
    regfile u_regfile (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_rs1_addr     (i_imem_data.r_fmt.rs1),
        .i_rs2_addr     (i_imem_data.r_fmt.rs2),
        .i_rd_addr      (i_imem_data.r_fmt.rd),
        .i_write_enable (reg_write & rst_n),
        .i_write_data   (wb_data),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data)
    );

    assign alu_src2 = (alu_source == ALU_SRC_IMM) ? imm : rs2_data;

    alu u_alu (
        .i_alu_control (alu_control),
        .i_src1        (rs1_data),
        .i_src2        (alu_src2),
        .o_result      (alu_result),
        .o_zero        (alu_zero),
        .o_last_bit    (alu_last_bit)
    );

    mem_access u_mem_access (
        .i_addr       (alu_result),
        .i_store_data (rs2_data),
        .i_funct3     (i_imem_data.r_fmt.funct3),
        .i_mem_write  (mem_write & rst_n),
        .i_rdata      (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_be    (o_dmem_be),
        .o_dmem_we    (o_dmem_we),
        .o_load_data  (load_data)
    );

endmodule

// File: tb_rv_core.sv
// Random RV32I program at address 0 with data at 0x400..0x7FF; checks pc, stores and final memory
module tb_rv_core;

    import rv_isa_pkg::*;

    localparam logic [31:0] RESET_ADDR = 32'h0000_0000;
    localparam int RESET_CYCLES = 8;
    localparam int STEPS = 2000;
    localparam int PROG_WORDS = 256;
    localparam int DATA_WORDS = 256;

    logic        clk;
    logic        rst_n;
    logic [31:0] o_imem_addr;
    instr_t      i_imem_data;
    logic [31:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic [3:0]  o_dmem_be;
    logic        o_dmem_we;
    logic [31:0] i_dmem_rdata;

    logic [31:0] imem [PROG_WORDS];
    logic [31:0] dmem [DATA_WORDS];
    logic [31:0] model_mem [DATA_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [31:0] seed;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    rv_core #(
        .RESET_ADDR(RESET_ADDR)
    ) i_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_be    (o_dmem_be),
        .o_dmem_we    (o_dmem_we),
        .i_dmem_rdata (i_dmem_rdata)
    );

    always #5 clk = ~clk;

    // Outside the program a NOP is fetched
    assign i_imem_data = (o_imem_addr[31:10] == 22'd0) ? imem[o_imem_addr[9:2]] : 32'h0000_0013;
    assign i_dmem_rdata = (o_dmem_addr[31:10] == 22'd1) ? dmem[o_dmem_addr[9:2]] : 32'h0;

    always @(posedge clk) begin
        if (o_dmem_we && o_dmem_addr[31:10] == 22'd1) begin
            for (int b = 0; b < 4; b++) begin
                if (o_dmem_be[b]) begin
                    dmem[o_dmem_addr[9:2]][8*b +: 8] <= o_dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    function automatic logic [31:0] enc_r(opcode_t op, logic [2:0] f3, logic [6:0] f7,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        instr_t w;
        w = '0;
        w.r_fmt.opcode = op;
        w.r_fmt.funct3 = f3;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rd = rd;
        w.r_fmt.rs1 = rs1;
        w.r_fmt.rs2 = rs2;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(opcode_t op, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        instr_t w;
        w = '0;
        w.i_fmt.opcode = op;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd = rd;
        w.i_fmt.rs1 = rs1;
        w.i_fmt.imm_11_0 = imm;
        return w;
    endfunction

    function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs2, logic [11:0] imm);
        instr_t w;
        w = '0;
        w.s_fmt.opcode = OP_STORE;
        w.s_fmt.funct3 = f3;
        w.s_fmt.rs2 = rs2;
        w.s_fmt.imm_11_5 = imm[11:5];
        w.s_fmt.imm_4_0 = imm[4:0];
        return w;
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        instr_t w;
        w = '0;
        w.b_fmt.opcode = OP_BRANCH;
        w.b_fmt.funct3 = f3;
        w.b_fmt.rs1 = rs1;
        w.b_fmt.rs2 = rs2;
        w.b_fmt.imm_12 = off[12];
        w.b_fmt.imm_11 = off[11];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.imm_4_1 = off[4:1];
        return w;
    endfunction

    function automatic logic [31:0] enc_u(opcode_t op, logic [4:0] rd, logic [19:0] imm);
        instr_t w;
        w = '0;
        w.u_fmt.opcode = op;
        w.u_fmt.rd = rd;
        w.u_fmt.imm_31_12 = imm;
        return w;
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        instr_t w;
        w = '0;
        w.j_fmt.opcode = OP_JAL;
        w.j_fmt.rd = rd;
        w.j_fmt.imm_20 = off[20];
        w.j_fmt.imm_19_12 = off[19:12];
        w.j_fmt.imm_11 = off[11];
        w.j_fmt.imm_10_1 = off[10:1];
        return w;
    endfunction

    // Data address with alignment to the access width
    function automatic logic [11:0] data_addr(logic [2:0] width);
        logic [31:0] a;
        a = 32'h400 + (lcg_next() % 256) * 4;
        if (width[1:0] == 2'd0) a = a + lcg_next() % 4;
        if (width[1:0] == 2'd1) a = a + (lcg_next() % 2) * 2;
        return a[11:0];
    endfunction

    task automatic gen_program();
        logic [2:0]  f3;
        logic [31:0] off;
        logic [2:0]  load_f3 [5];
        logic [2:0]  br_f3 [6];
        int          i;
        load_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        // A store at the reset address shows whether the strobe is held off in reset
        imem[0] = enc_s(3'd2, 5'd0, data_addr(3'd2));
        i = 1;
        while (i < PROG_WORDS - 1) begin
            off = (lcg_next() % PROG_WORDS) * 4 - i * 4;
            case (lcg_next() % 16)
                0, 1, 2, 3: begin
                    f3 = 3'(lcg_next());
                    imem[i] = enc_i(OP_IMM, f3, 5'(lcg_next()), 5'(lcg_next()),
                                    12'(lcg_next()));
                    if (f3 == 3'd1) imem[i][31:25] = 7'd0;
                    if (f3 == 3'd5) imem[i][31:25] = lcg_next() % 2 ? 7'h20 : 7'h00;
                end
                4, 5: begin
                    f3 = 3'(lcg_next());
                    imem[i] = enc_r(OP_OP, f3, (f3 == 3'd0 || f3 == 3'd5) &&
                                    lcg_next() % 2 ? 7'h20 : 7'h00,
                                    5'(lcg_next()), 5'(lcg_next()), 5'(lcg_next()));
                end
                6: imem[i] = enc_u(OP_LUI, 5'(lcg_next()), 20'(lcg_next()));
                7: imem[i] = enc_u(OP_AUIPC, 5'(lcg_next()), 20'(lcg_next()));
                8, 9: begin
                    // Load, then store the loaded register elsewhere
                    f3 = load_f3[lcg_next() % 5];
                    imem[i] = enc_i(OP_LOAD, f3, 5'(lcg_next()), 5'd0, data_addr(f3));
                    if (i < PROG_WORDS - 2) begin
                        i++;
                        imem[i] = enc_s(3'd2, imem[i-1][11:7], data_addr(3'd2));
                    end
                end
                10, 11, 12: begin
                    f3 = 3'(lcg_next() % 3);
                    imem[i] = enc_s(f3, 5'(lcg_next()), data_addr(f3));
                end
                13: imem[i] = enc_b(br_f3[lcg_next() % 6], 5'(lcg_next()), 5'(lcg_next()),
                                    13'(off));
                14: imem[i] = enc_j(5'(lcg_next()), 21'(off));
                default: imem[i] = enc_i(OP_JALR, 3'd0, 5'(lcg_next()), 5'd0,
                                         12'((lcg_next() % PROG_WORDS) * 4));
            endcase
            i++;
        end
        imem[PROG_WORDS-1] = enc_j(5'd0, 21'(-(PROG_WORDS - 1) * 4));
    endtask

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] x,
                                            logic [31:0] y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'd0, $signed(x) < $signed(y)};
            3'd3: return {31'd0, x < y};
            3'd4: return x ^ y;
            3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // One instruction of the reference model; also returns the expected store strobe
    task automatic model_step(output logic st_we, output logic [31:0] st_addr,
                              output logic [3:0] st_be, output logic [31:0] st_data);
        logic [31:0] ins, a, b, imm_i, imm_s, addr, nxt, word, res;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr, taken;
        int          lo;
        int          size;
        ins = imem[model_pc[9:2]];
        rd = ins[11:7];
        f3 = ins[14:12];
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        nxt = model_pc + 4;
        wr = 1'b1;
        res = 32'h0;
        st_we = 1'b0;
        st_addr = 32'h0;
        st_be = 4'h0;
        st_data = 32'h0;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'h0};
            7'b0010111: res = model_pc + {ins[31:12], 12'h0};
            7'b1101111: begin
                res = model_pc + 4;
                nxt = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res = model_pc + 4;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) begin
                    nxt = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b0000011: begin
                addr = a + imm_i;
                word = model_mem[addr[9:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'd0: res = {{24{word[7]}}, word[7:0]};
                    3'd1: res = {{16{word[15]}}, word[15:0]};
                    3'd4: res = {24'd0, word[7:0]};
                    3'd5: res = {16'd0, word[15:0]};
                    default: res = word;
                endcase
            end
            7'b0100011: begin
                wr = 1'b0;
                addr = a + imm_s;
                st_we = 1'b1;
                st_addr = {addr[31:2], 2'b00};
                // Enabled bytes run from the address up through the access size
                lo = 32'(addr[1:0]);
                size = 1 << f3[1:0];
                for (int k = 0; k < 4; k++) begin
                    st_be[k] = k >= lo && k < lo + size;
                end
                st_data = b << (8 * addr[1:0]);
                for (int k = 0; k < 4; k++) begin
                    if (st_be[k]) model_mem[addr[9:2]][8*k +: 8] = st_data[8*k +: 8];
                end
            end
            7'b0010011: res = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
            default: res = alu_ref(f3, ins[30], a, b);
        endcase
        if (wr && rd != 5'd0) model_regs[rd] = res;
        model_pc = nxt;
    endtask

    task automatic check_pc(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_store(string name, logic exp_we, logic [31:0] exp_addr,
                               logic [3:0] exp_be, logic [31:0] exp_data);
        logic [31:0] mask;
        mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
        if (o_dmem_we !== exp_we) begin
            $display("%s: store strobe was %b where the model gives %b", name, o_dmem_we, exp_we);
            errors++;
        end else if (exp_we && (o_dmem_addr !== exp_addr || o_dmem_be !== exp_be ||
                                (o_dmem_wdata & mask) !== (exp_data & mask))) begin
            $display("mismatch %s: expected %h/%b/%h actual %h/%b/%h", name, exp_addr,
                     exp_be, exp_data & mask, o_dmem_addr, o_dmem_be, o_dmem_wdata & mask);
            errors++;
        end
    endtask

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        #((RESET_CYCLES + STEPS + 20) * 10);
        $display("timeout: the run did not finish in the expected time");
        $display("sim failed");
        $finish;
    end

    initial begin
        logic        st_we;
        logic [31:0] st_addr;
        logic [3:0]  st_be;
        logic [31:0] st_data;
        int          mark;
        clk = 1'b0;
        rst_n = 1'b0;
        seed = 32'hb3f6_bbbd;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        gen_program();
        // Fill word depends on the full byte address
        for (int i = 0; i < DATA_WORDS; i++) begin
            model_mem[i] = (32'h400 + i * 4) * 32'h9e37_79b9 ^ (32'h400 + i * 4);
            dmem[i] <= model_mem[i];
        end
        for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;
        model_pc = RESET_ADDR;

        mark = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_pc("reset_pc", RESET_ADDR, o_imem_addr);
            if (o_dmem_we !== 1'b0) begin
                $display("reset: store strobe active while reset is held");
                errors++;
            end
        end
        report_test("reset", mark);
        rst_n = 1'b1;

        mark = errors;
        for (int s = 0; s < STEPS; s++) begin
            if (s > 0) @(negedge clk);
            #1;
            check_pc("fetch_pc", model_pc, o_imem_addr);
            model_step(st_we, st_addr, st_be, st_data);
            check_store("store", st_we, st_addr, st_be, st_data);
        end
        report_test("program", mark);

        @(negedge clk);
        mark = errors;
        for (int i = 0; i < DATA_WORDS; i++) begin
            check_word("data_dump", model_mem[i], dmem[i]);
        end
        report_test("memory_dump", mark);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: rv_core.f
rv_isa_pkg.sv
rv_ctrl_pkg.sv
fetch_unit.sv
decode_control.sv
imm_gen.sv
regfile.sv
alu.sv
mem_access.sv
rv_core.sv
tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_rv_core
RTL_TOP   = rv_core
FILELIST  = rv_core.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
